//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core -f all.f
	./obj_dir/Vtb_ooo_core | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
src/rv_isa_pkg.sv
src/core_cfg_pkg.sv
src/instr_decode.sv
src/rename_regfile.sv
src/alu_station.sv
src/reorder_buffer.sv
src/ooo_core.sv
sim/ooo_core_assert.sv
sim/tb_ooo_core.sv

//--- sim/core_tests.mem
// test  instruction  rd  value   (one record per line, hex)
// instruction 00000000 closes the test, test 00 closes the file
01 12300093 01 00000123  // addi x1, x0, 0x123
01 FFB00113 02 FFFFFFFB  // addi x2, x0, -5
01 00400193 03 00000004  // addi x3, x0, 4
01 00208533 0A 0000011E  // add  x10, x1, x2
01 402085B3 0B 00000128  // sub  x11, x1, x2
01 00309633 0C 00001230  // sll  x12, x1, x3
01 001126B3 0D 00000001  // slt  x13, x2, x1
01 00113733 0E 00000000  // sltu x14, x2, x1
01 0020C7B3 0F FFFFFED8  // xor  x15, x1, x2
01 00315833 10 0FFFFFFF  // srl  x16, x2, x3
01 403158B3 11 FFFFFFFF  // sra  x17, x2, x3
01 0020E933 12 FFFFFFFB  // or   x18, x1, x2
01 0020F9B3 13 00000123  // and  x19, x1, x2
01 00000000 00 00000000
02 FFF12213 04 00000001  // slti  x4, x2, -1
02 FFF0B293 05 00000001  // sltiu x5, x1, -1
02 FFF0C313 06 FFFFFEDC  // xori  x6, x1, -1
02 7000E393 07 00000723  // ori   x7, x1, 0x700
02 7F017413 08 000007F0  // andi  x8, x2, 0x7f0
02 00809493 09 00012300  // slli  x9, x1, 8
02 01C15A13 14 0000000F  // srli  x20, x2, 28
02 40115A93 15 FFFFFFFD  // srai  x21, x2, 1
02 ABCDEB37 16 ABCDE000  // lui   x22, 0xabcde
02 80000B93 17 FFFFF800  // addi  x23, x0, -2048
02 00708013 00 0000012A  // addi  x0, x1, 7
02 00100C33 18 00000123  // add   x24, x0, x1
02 00000CB3 19 00000000  // add   x25, x0, x0
02 00000000 00 00000000
03 00100D13 1A 00000001  // addi x26, x0, 1
03 01AD0D33 1A 00000002  // add  x26, x26, x26
03 01AD0D33 1A 00000004  // add  x26, x26, x26
03 003D1D93 1B 00000020  // slli x27, x26, 3
03 41AD8E33 1C 0000001C  // sub  x28, x27, x26
03 01BE4EB3 1D 0000003C  // xor  x29, x28, x27
03 FC4E8D13 1A 00000000  // addi x26, x29, -60
03 01CD6F33 1E 0000001C  // or   x30, x26, x28
03 00000000 00 00000000
04 123452B7 05 12345000  // lui  x5, 0x12345
04 67828293 05 12345678  // addi x5, x5, 0x678
04 0102D313 06 00001234  // srli x6, x5, 16
04 0FF2F393 07 00000078  // andi x7, x5, 0xff
04 0063B433 08 00000001  // sltu x8, x7, x6
04 007304B3 09 000012AC  // add  x9, x6, x7
04 00000000 00 00000000
05 001F8F93 1F 00000001  // addi x31, x31, 1
05 001F8F93 1F 00000002
05 001F8F93 1F 00000003
05 001F8F93 1F 00000004
05 001F8F93 1F 00000005
05 001F8F93 1F 00000006
05 001F8F93 1F 00000007
05 001F8F93 1F 00000008
05 001F8F93 1F 00000009
05 001F8F93 1F 0000000A
05 01FF8F33 1E 00000014  // add  x30, x31, x31
05 01FF4FB3 1F 0000001E  // xor  x31, x30, x31
05 00000000 00 00000000
00 00000000 00 00000000

//--- sim/ooo_core_assert.sv
`timescale 1ns/100ps

module ooo_core_assert (
  input logic                   clk_100mhz,
  input logic                   sys_rst,
  input core_cfg_pkg::rob_cnt_t i_count,
  input logic                   i_issue,
  input core_cfg_pkg::rob_tag_t i_tail,
  input logic                   i_cdb_valid,
  input core_cfg_pkg::rob_tag_t i_cdb_tag,
  input logic                   i_commit_valid,
  input core_cfg_pkg::rob_tag_t i_commit_tag
);

  logic [core_cfg_pkg::rob_depth-1:0] written;   // slot got its result on the cdb
  core_cfg_pkg::rob_cnt_t             inflight;  // issued, commit not yet seen

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      written  <= '0;
      inflight <= '0;
    end else begin
      inflight <= inflight + core_cfg_pkg::rob_cnt_t'(i_issue)
                           - core_cfg_pkg::rob_cnt_t'(i_commit_valid);
      if (i_issue) begin
        written[i_tail] <= 1'b0;  // slot handed to a new instruction
      end
      if (i_cdb_valid) begin
        written[i_cdb_tag] <= 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_count <= core_cfg_pkg::rob_cnt_t'(core_cfg_pkg::rob_depth))
    else $error("reorder buffer count above its depth");

  // committed slot must have seen its result on the bus
  a_commit_done_head: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_commit_valid |-> written[i_commit_tag])
    else $error("commit without a finished head entry");

  a_no_commit_empty: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_commit_valid |-> (inflight != '0))
    else $error("commit while the reorder buffer was empty");

endmodule

bind reorder_buffer ooo_core_assert u_rob_assert (
  .clk_100mhz     (clk_100mhz),
  .sys_rst        (sys_rst),
  .i_count        (count),
  .i_issue        (i_issue),
  .i_tail         (tail),
  .i_cdb_valid    (i_cdb_valid),
  .i_cdb_tag      (i_cdb_tag),
  .i_commit_valid (o_commit_valid),
  .i_commit_tag   (o_commit_tag)
);

//--- sim/tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;

  localparam int mem_words     = 256;  // four words per record
  localparam int burst_test    = 5;    // issued back to back, no gaps
  localparam int ready_timeout = 100;
  localparam int drain_timeout = 200;

  logic                        clk_100mhz;
  logic                        sys_rst;
  logic                        i_inst_valid;
  logic [rv_isa_pkg::xlen-1:0] i_inst;
  logic                        o_inst_ready;
  logic                        o_commit_valid;
  rv_isa_pkg::reg_addr_t       o_commit_rd;
  logic [rv_isa_pkg::xlen-1:0] o_commit_value;

  logic [31:0]                 vec [mem_words];
  rv_isa_pkg::reg_addr_t       exp_rd [$];   // commits still owed, oldest first
  logic [rv_isa_pkg::xlen-1:0] exp_val [$];
  int                          errors;
  int                          tests_run;
  int                          tests_failed;
  int                          stall_cycles;  // valid high while ready low
  bit                          timed_out;

  ooo_core u_ooo_core (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .o_inst_ready   (o_inst_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_value (o_commit_value)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  task automatic check_rd(input rv_isa_pkg::reg_addr_t got, input rv_isa_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: commit rd is x%0d, expected x%0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_value(input logic [rv_isa_pkg::xlen-1:0] got,
                             input logic [rv_isa_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: commit value is %08h, expected %08h", $time, got, exp);
      errors++;
    end
  endtask

  // commit outputs are registered, stable at the falling edge
  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      if (exp_rd.size() == 0) begin
        $display("commit of x%0d at %0t ns with no instruction outstanding", o_commit_rd, $time);
        errors++;
      end else begin
        check_rd(o_commit_rd, exp_rd.pop_front());
        check_value(o_commit_value, exp_val.pop_front());
      end
    end
  end

  task automatic check_idle();
    int bad;
    bad = 0;
    repeat (6) begin
      @(posedge clk_100mhz);
      #1;
      if (o_commit_valid !== 1'b0 || o_inst_ready !== 1'b1) bad++;
    end
    tests_run++;
    if (bad != 0) begin
      $display("idle after reset: commit valid or ready wrong in %0d cycles", bad);
      errors++;
      tests_failed++;
    end
    $display("test idle: %s", bad == 0 ? "ok" : "FAIL");
  endtask

  // called at edge + 1 ns, returns at edge + 1 ns after the transfer
  task automatic issue_inst(input logic [31:0] word, output bit ok);
    int waited;
    waited       = 0;
    i_inst_valid = 1'b1;
    i_inst       = word;
    while (!o_inst_ready && waited < ready_timeout) begin
      stall_cycles++;
      @(posedge clk_100mhz);
      #1;
      waited++;
    end
    ok = o_inst_ready;
    if (!ok) begin
      $display("no transfer: o_inst_ready stayed low for %0d cycles", waited);
      timed_out = 1'b1;
    end else begin
      @(posedge clk_100mhz);  // handshake edge
      #1;
    end
    i_inst_valid = 1'b0;
  endtask

  task automatic wait_drain(output bit ok);
    int waited;
    waited = 0;
    while (exp_rd.size() != 0 && waited < drain_timeout) begin
      @(posedge clk_100mhz);
      #1;
      waited++;
    end
    ok = (exp_rd.size() == 0);
    if (!ok) begin
      $display("commits stopped with %0d instructions still outstanding", exp_rd.size());
      timed_out = 1'b1;
    end
  endtask

  initial begin
    int                   rec;
    int                   gap;
    int                   seed;
    int                   start_errors;
    int                   test_insts;
    logic [7:0]           test_num;
    rv_isa_pkg::inst_u    word;
    bit                   ok;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    stall_cycles = 0;
    timed_out    = 1'b0;
    seed         = $urandom(27);
    $readmemh("sim/core_tests.mem", vec);
    repeat (4) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    check_idle();
    rec          = 0;
    ok           = 1'b1;
    start_errors = errors;
    test_insts   = 0;
    stall_cycles = 0;
    if (vec[0] == '0) begin
      $display("no records found in sim/core_tests.mem");
      errors++;
    end
    while (ok && rec < mem_words / 4 && vec[rec*4] != '0) begin
      test_num = vec[rec*4][7:0];
      word     = vec[rec*4+1];
      if (word == '0) begin  // end of test
        wait_drain(ok);
        if (test_num == burst_test && stall_cycles == 0) begin
          $display("test %0d: o_inst_ready never fell during the burst", test_num);
          errors++;
        end
        tests_run++;
        if (errors != start_errors) tests_failed++;
        $display("test %0d: %0d instructions, %0d stall cycles, %s", test_num, test_insts,
                 stall_cycles, errors == start_errors ? "ok" : "FAIL");
        start_errors = errors;
        test_insts   = 0;
        stall_cycles = 0;
      end else begin
        if (word.r.rd != rv_isa_pkg::reg_addr_t'(vec[rec*4+2])) begin
          $display("record %0d: instruction rd field differs from the expected rd", rec);
          errors++;
        end
        exp_rd.push_back(rv_isa_pkg::reg_addr_t'(vec[rec*4+2]));
        exp_val.push_back(vec[rec*4+3]);
        if (test_num != burst_test) begin
          gap = $urandom % 4;
          repeat (gap) begin
            @(posedge clk_100mhz);
            #1;
          end
        end
        issue_inst(word, ok);
        test_insts++;
      end
      rec++;
    end
    repeat (4) @(posedge clk_100mhz);  // catch stray commits
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/alu_station.sv
`timescale 1ns/100ps

module alu_station (
  input  logic                         clk_100mhz,
  input  logic                         sys_rst,
  input  logic                         i_issue,
  input  rv_isa_pkg::alu_func_t        i_func,
  input  core_cfg_pkg::rob_tag_t       i_issue_tag,
  input  logic                         i_use_imm,
  input  logic [rv_isa_pkg::xlen-1:0]  i_imm,
  input  logic [rv_isa_pkg::xlen-1:0]  i_val1,
  input  logic [rv_isa_pkg::xlen-1:0]  i_val2,
  input  logic                         i_busy1,
  input  logic                         i_busy2,
  input  core_cfg_pkg::rob_tag_t       i_tag1,
  input  core_cfg_pkg::rob_tag_t       i_tag2,
  input  logic                         i_rob_done1,
  input  logic                         i_rob_done2,
  input  logic [rv_isa_pkg::xlen-1:0]  i_rob_val1,
  input  logic [rv_isa_pkg::xlen-1:0]  i_rob_val2,
  output logic                         o_free,
  output logic                         o_cdb_valid,
  output core_cfg_pkg::rob_tag_t       o_cdb_tag,
  output logic [rv_isa_pkg::xlen-1:0]  o_cdb_value
);

  logic [core_cfg_pkg::rs_depth-1:0] valid;
  logic [core_cfg_pkg::rs_depth-1:0] rdy_i;
  logic [core_cfg_pkg::rs_depth-1:0] rdy_j;
  logic [core_cfg_pkg::rs_depth-1:0] wake_i;  // waiting operand seen on cdb
  logic [core_cfg_pkg::rs_depth-1:0] wake_j;
  rv_isa_pkg::alu_func_t             func [core_cfg_pkg::rs_depth];
  logic [rv_isa_pkg::xlen-1:0]       vi   [core_cfg_pkg::rs_depth];
  logic [rv_isa_pkg::xlen-1:0]       vj   [core_cfg_pkg::rs_depth];
  core_cfg_pkg::rob_tag_t            qi   [core_cfg_pkg::rs_depth];
  core_cfg_pkg::rob_tag_t            qj   [core_cfg_pkg::rs_depth];
  core_cfg_pkg::rob_tag_t            dest [core_cfg_pkg::rs_depth];
  core_cfg_pkg::rs_idx_t             alloc_idx;
  core_cfg_pkg::rs_idx_t             pick_idx;
  logic                              pick_found;
  logic                              op1_rdy;
  logic                              op2_rdy;
  logic [rv_isa_pkg::xlen-1:0]       op1_val;
  logic [rv_isa_pkg::xlen-1:0]       op2_val;
  logic [rv_isa_pkg::xlen-1:0]       src_a;
  logic [rv_isa_pkg::xlen-1:0]       src_b;
  logic [rv_isa_pkg::xlen-1:0]       alu_result;

  // {ready, value}: regfile, then rob, then this cycle's cdb
  function automatic logic [rv_isa_pkg::xlen:0] resolve(
    input logic                        busy,
    input core_cfg_pkg::rob_tag_t      tag,
    input logic [rv_isa_pkg::xlen-1:0] rf_val,
    input logic                        rob_done,
    input logic [rv_isa_pkg::xlen-1:0] rob_val
  );
    if (!busy) return {1'b1, rf_val};
    if (rob_done) return {1'b1, rob_val};
    if (o_cdb_valid && o_cdb_tag == tag) return {1'b1, o_cdb_value};
    return {1'b0, rf_val};  // keep the tag, capture later
  endfunction

  always_comb begin
    {op1_rdy, op1_val} = resolve(i_busy1, i_tag1, i_val1, i_rob_done1, i_rob_val1);
    {op2_rdy, op2_val} = i_use_imm ? {1'b1, i_imm}
                                   : resolve(i_busy2, i_tag2, i_val2, i_rob_done2, i_rob_val2);
  end

  // lowest free slot for allocation, lowest ready slot for dispatch
  always_comb begin
    alloc_idx  = '0;
    pick_idx   = '0;
    pick_found = 1'b0;
    for (int e = core_cfg_pkg::rs_depth - 1; e >= 0; e--) begin
      if (!valid[e]) begin
        alloc_idx = core_cfg_pkg::rs_idx_t'(e);
      end
      if (valid[e] && rdy_i[e] && rdy_j[e]) begin
        pick_idx   = core_cfg_pkg::rs_idx_t'(e);
        pick_found = 1'b1;
      end
    end
  end

  always_comb begin
    for (int e = 0; e < core_cfg_pkg::rs_depth; e++) begin
      wake_i[e] = valid[e] && !rdy_i[e] && o_cdb_valid && (o_cdb_tag == qi[e]);
      wake_j[e] = valid[e] && !rdy_j[e] && o_cdb_valid && (o_cdb_tag == qj[e]);
    end
  end

  assign o_free = ~&valid;
  assign src_a  = vi[pick_idx];
  assign src_b  = vj[pick_idx];

  always_comb begin
    case (func[pick_idx])
      rv_isa_pkg::ADD:    alu_result = src_a + src_b;
      rv_isa_pkg::SUB:    alu_result = src_a - src_b;
      rv_isa_pkg::SLL:    alu_result = src_a << src_b[4:0];
      rv_isa_pkg::SLT:    alu_result = {{(rv_isa_pkg::xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      rv_isa_pkg::SLTU:   alu_result = {{(rv_isa_pkg::xlen-1){1'b0}}, src_a < src_b};
      rv_isa_pkg::XOR:    alu_result = src_a ^ src_b;
      rv_isa_pkg::SRL:    alu_result = src_a >> src_b[4:0];
      rv_isa_pkg::SRA:    alu_result = $signed(src_a) >>> src_b[4:0];
      rv_isa_pkg::OR:     alu_result = src_a | src_b;
      rv_isa_pkg::AND:    alu_result = src_a & src_b;
      rv_isa_pkg::PASS_B: alu_result = src_b;
      default:            alu_result = '0;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      valid       <= '0;
      rdy_i       <= '0;
      rdy_j       <= '0;
      o_cdb_valid <= 1'b0;
    end else begin
      o_cdb_valid <= pick_found;
      rdy_i       <= rdy_i | wake_i;
      rdy_j       <= rdy_j | wake_j;
      if (pick_found) begin
        valid[pick_idx] <= 1'b0;  // entry leaves on dispatch
      end
      if (i_issue) begin
        valid[alloc_idx] <= 1'b1;
        rdy_i[alloc_idx] <= op1_rdy;
        rdy_j[alloc_idx] <= op2_rdy;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    o_cdb_tag   <= dest[pick_idx];
    o_cdb_value <= alu_result;
    for (int e = 0; e < core_cfg_pkg::rs_depth; e++) begin
      if (wake_i[e]) begin
        vi[e] <= o_cdb_value;
      end
      if (wake_j[e]) begin
        vj[e] <= o_cdb_value;
      end
    end
    if (i_issue) begin
      func[alloc_idx] <= i_func;
      vi[alloc_idx]   <= op1_val;
      vj[alloc_idx]   <= op2_val;
      qi[alloc_idx]   <= i_tag1;
      qj[alloc_idx]   <= i_tag2;
      dest[alloc_idx] <= i_issue_tag;
    end
  end

endmodule

//--- src/core_cfg_pkg.sv
package core_cfg_pkg;

  localparam int rob_depth = 8;
  localparam int rs_depth  = 4;

  localparam int rob_tag_w = $clog2(rob_depth);
  localparam int rs_idx_w  = $clog2(rs_depth);

  // slot number in the reorder buffer, doubles as the rename tag
  typedef logic [rob_tag_w-1:0] rob_tag_t;

  // occupancy count, one bit wider so full is representable
  typedef logic [rob_tag_w:0] rob_cnt_t;

  typedef logic [rs_idx_w-1:0] rs_idx_t;

endpackage

//--- src/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
  input  rv_isa_pkg::inst_u            i_inst,
  output rv_isa_pkg::alu_func_t        o_func,
  output rv_isa_pkg::reg_addr_t        o_rs1,
  output rv_isa_pkg::reg_addr_t        o_rs2,
  output rv_isa_pkg::reg_addr_t        o_rd,
  output logic [rv_isa_pkg::xlen-1:0]  o_imm,
  output logic                         o_use_imm
);

  logic                  alt;        // bit 30 selects sub / sra
  rv_isa_pkg::alu_func_t base_func;  // from funct3 alone

  // addi has no sub form, only the shift-right immediates look at bit 30
  assign alt = i_inst.r.funct7[5] &&
               (i_inst.r.opcode == rv_isa_pkg::OP || i_inst.r.funct3 == 3'b101);

  always_comb begin
    case (i_inst.r.funct3)
      3'b000:  base_func = alt ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
      3'b001:  base_func = rv_isa_pkg::SLL;
      3'b010:  base_func = rv_isa_pkg::SLT;
      3'b011:  base_func = rv_isa_pkg::SLTU;
      3'b100:  base_func = rv_isa_pkg::XOR;
      3'b101:  base_func = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
      3'b110:  base_func = rv_isa_pkg::OR;
      default: base_func = rv_isa_pkg::AND;
    endcase
  end

  always_comb begin
    o_rd      = i_inst.r.rd;
    o_rs1     = i_inst.r.rs1;
    o_rs2     = i_inst.r.rs2;
    o_imm     = {{(rv_isa_pkg::xlen-12){i_inst.i.imm[11]}}, i_inst.i.imm};
    o_use_imm = 1'b0;
    o_func    = base_func;
    case (i_inst.r.opcode)
      rv_isa_pkg::OPIMM: begin
        o_rs2     = '0;  // these bits are immediate, not a register
        o_use_imm = 1'b1;
      end
      rv_isa_pkg::LUI: begin
        o_rs1     = '0;
        o_rs2     = '0;
        o_imm     = {i_inst.u.imm, 12'b0};
        o_use_imm = 1'b1;
        o_func    = rv_isa_pkg::PASS_B;
      end
      default: ;  // OP reads both registers
    endcase
  end

endmodule

//--- src/ooo_core.sv
`timescale 1ns/100ps

module ooo_core (
  input  logic                         clk_100mhz,
  input  logic                         sys_rst,
  input  logic                         i_inst_valid,
  input  logic [rv_isa_pkg::xlen-1:0]  i_inst,
  output logic                         o_inst_ready,
  output logic                         o_commit_valid,
  output rv_isa_pkg::reg_addr_t        o_commit_rd,
  output logic [rv_isa_pkg::xlen-1:0]  o_commit_value
);

  rv_isa_pkg::alu_func_t       func;
  rv_isa_pkg::reg_addr_t       rs1;
  rv_isa_pkg::reg_addr_t       rs2;
  rv_isa_pkg::reg_addr_t       rd;
  logic [rv_isa_pkg::xlen-1:0] imm;
  logic                        use_imm;
  logic                        issue;  // handshake fired
  logic [rv_isa_pkg::xlen-1:0] rf_val1;
  logic [rv_isa_pkg::xlen-1:0] rf_val2;
  logic                        rf_busy1;
  logic                        rf_busy2;
  core_cfg_pkg::rob_tag_t      rf_tag1;
  core_cfg_pkg::rob_tag_t      rf_tag2;
  logic                        rob_done1;
  logic                        rob_done2;
  logic [rv_isa_pkg::xlen-1:0] rob_val1;
  logic [rv_isa_pkg::xlen-1:0] rob_val2;
  logic                        rob_free;
  logic                        rs_free;
  core_cfg_pkg::rob_tag_t      tail_tag;
  core_cfg_pkg::rob_tag_t      commit_tag;
  logic                        cdb_valid;
  core_cfg_pkg::rob_tag_t      cdb_tag;
  logic [rv_isa_pkg::xlen-1:0] cdb_value;

  assign o_inst_ready = rob_free && rs_free;  // independent of valid
  assign issue        = i_inst_valid && o_inst_ready;

  instr_decode u_decode (
    .i_inst    (i_inst),
    .o_func    (func),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (rd),
    .o_imm     (imm),
    .o_use_imm (use_imm)
  );

  rename_regfile u_regfile (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .i_issue        (issue),
    .i_rd           (rd),
    .i_issue_tag    (tail_tag),
    .i_commit_valid (o_commit_valid),
    .i_commit_tag   (commit_tag),
    .i_commit_rd    (o_commit_rd),
    .i_commit_value (o_commit_value),
    .o_val1         (rf_val1),
    .o_val2         (rf_val2),
    .o_busy1        (rf_busy1),
    .o_busy2        (rf_busy2),
    .o_tag1         (rf_tag1),
    .o_tag2         (rf_tag2)
  );

  alu_station u_station (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_issue     (issue),
    .i_func      (func),
    .i_issue_tag (tail_tag),
    .i_use_imm   (use_imm),
    .i_imm       (imm),
    .i_val1      (rf_val1),
    .i_val2      (rf_val2),
    .i_busy1     (rf_busy1),
    .i_busy2     (rf_busy2),
    .i_tag1      (rf_tag1),
    .i_tag2      (rf_tag2),
    .i_rob_done1 (rob_done1),
    .i_rob_done2 (rob_done2),
    .i_rob_val1  (rob_val1),
    .i_rob_val2  (rob_val2),
    .o_free      (rs_free),
    .o_cdb_valid (cdb_valid),
    .o_cdb_tag   (cdb_tag),
    .o_cdb_value (cdb_value)
  );

  reorder_buffer u_rob (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_issue        (issue),
    .i_rd           (rd),
    .i_lookup_tag1  (rf_tag1),
    .i_lookup_tag2  (rf_tag2),
    .i_cdb_valid    (cdb_valid),
    .i_cdb_tag      (cdb_tag),
    .i_cdb_value    (cdb_value),
    .o_free         (rob_free),
    .o_tail_tag     (tail_tag),
    .o_done1        (rob_done1),
    .o_done2        (rob_done2),
    .o_val1         (rob_val1),
    .o_val2         (rob_val2),
    .o_commit_valid (o_commit_valid),
    .o_commit_tag   (commit_tag),
    .o_commit_rd    (o_commit_rd),
    .o_commit_value (o_commit_value)
  );

endmodule

//--- src/rename_regfile.sv
`timescale 1ns/100ps

module rename_regfile (
  input  logic                         clk_100mhz,
  input  logic                         sys_rst,
  input  rv_isa_pkg::reg_addr_t        i_rs1,
  input  rv_isa_pkg::reg_addr_t        i_rs2,
  input  logic                         i_issue,
  input  rv_isa_pkg::reg_addr_t        i_rd,
  input  core_cfg_pkg::rob_tag_t       i_issue_tag,
  input  logic                         i_commit_valid,
  input  core_cfg_pkg::rob_tag_t       i_commit_tag,
  input  rv_isa_pkg::reg_addr_t        i_commit_rd,
  input  logic [rv_isa_pkg::xlen-1:0]  i_commit_value,
  output logic [rv_isa_pkg::xlen-1:0]  o_val1,
  output logic [rv_isa_pkg::xlen-1:0]  o_val2,
  output logic                         o_busy1,
  output logic                         o_busy2,
  output core_cfg_pkg::rob_tag_t       o_tag1,
  output core_cfg_pkg::rob_tag_t       o_tag2
);

  logic [rv_isa_pkg::xlen-1:0] regs [32];
  logic [31:0]                 busy;
  core_cfg_pkg::rob_tag_t      tags [32];
  logic                        wr_en;
  logic                        clr_busy;  // commit is the newest rename of rd
  logic                        fwd1;
  logic                        fwd2;

  assign wr_en    = i_commit_valid && (i_commit_rd != '0);  // x0 stays zero
  assign clr_busy = wr_en && (tags[i_commit_rd] == i_commit_tag);

  // same-cycle commit bypass
  assign fwd1 = clr_busy && (i_commit_rd == i_rs1);
  assign fwd2 = clr_busy && (i_commit_rd == i_rs2);

  assign o_val1  = fwd1 ? i_commit_value : regs[i_rs1];
  assign o_val2  = fwd2 ? i_commit_value : regs[i_rs2];
  assign o_busy1 = busy[i_rs1] && !fwd1;
  assign o_busy2 = busy[i_rs2] && !fwd2;
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wr_en) begin
        regs[i_commit_rd] <= i_commit_value;
      end
      if (clr_busy) begin
        busy[i_commit_rd] <= 1'b0;
      end
      if (i_issue && i_rd != '0) begin
        busy[i_rd] <= 1'b1;  // new rename beats the clear
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue && i_rd != '0) begin
      tags[i_rd] <= i_issue_tag;
    end
  end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                         clk_100mhz,
  input  logic                         sys_rst,
  input  logic                         i_issue,
  input  rv_isa_pkg::reg_addr_t        i_rd,
  input  core_cfg_pkg::rob_tag_t       i_lookup_tag1,
  input  core_cfg_pkg::rob_tag_t       i_lookup_tag2,
  input  logic                         i_cdb_valid,
  input  core_cfg_pkg::rob_tag_t       i_cdb_tag,
  input  logic [rv_isa_pkg::xlen-1:0]  i_cdb_value,
  output logic                         o_free,
  output core_cfg_pkg::rob_tag_t       o_tail_tag,
  output logic                         o_done1,
  output logic                         o_done2,
  output logic [rv_isa_pkg::xlen-1:0]  o_val1,
  output logic [rv_isa_pkg::xlen-1:0]  o_val2,
  output logic                         o_commit_valid,
  output core_cfg_pkg::rob_tag_t       o_commit_tag,
  output rv_isa_pkg::reg_addr_t        o_commit_rd,
  output logic [rv_isa_pkg::xlen-1:0]  o_commit_value
);

  logic [core_cfg_pkg::rob_depth-1:0] done;
  rv_isa_pkg::reg_addr_t              dest_rd [core_cfg_pkg::rob_depth];
  logic [rv_isa_pkg::xlen-1:0]        result  [core_cfg_pkg::rob_depth];
  core_cfg_pkg::rob_tag_t             head;  // oldest in flight
  core_cfg_pkg::rob_tag_t             tail;  // next slot to hand out
  core_cfg_pkg::rob_cnt_t             count;
  logic                               retire;

  // head leaves on this edge, commit record shows up next cycle
  assign retire = (count != '0) && done[head];

  assign o_free     = count != core_cfg_pkg::rob_cnt_t'(core_cfg_pkg::rob_depth);
  assign o_tail_tag = tail;

  // operand lookups for the station
  assign o_done1 = done[i_lookup_tag1];
  assign o_done2 = done[i_lookup_tag2];
  assign o_val1  = result[i_lookup_tag1];
  assign o_val2  = result[i_lookup_tag2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      done           <= '0;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= retire;
      if (retire) begin
        head <= head + 1'b1;  // wraps, depth is a power of two
      end
      if (i_issue) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (i_cdb_valid) begin
        done[i_cdb_tag] <= 1'b1;
      end
      case ({i_issue, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue) begin
      dest_rd[tail] <= i_rd;
    end
    if (i_cdb_valid) begin
      result[i_cdb_tag] <= i_cdb_value;
    end
    if (retire) begin
      o_commit_tag   <= head;
      o_commit_rd    <= dest_rd[head];
      o_commit_value <= result[head];
    end
  end

endmodule

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // only the major opcodes this core accepts
  typedef enum logic [6:0] {
    OP    = 7'b0110011,
    OPIMM = 7'b0010011,
    LUI   = 7'b0110111
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU,
    XOR, SRL, SRA, OR, AND,
    PASS_B  // second operand straight through, for lui
  } alu_func_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;  // upper 20 bits of the result
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_fmt_t;

  // one instruction word, three ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_u;

endpackage
